// ==== soc_settings.svh ====
// ------------------------------------------------
// SoC settings
// Region codes, memory size, reset hold count,
// UART baud divisor and transmit FIFO depth
// ------------------------------------------------
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// Top address byte selects the region
`define BASE_MEM            8'h00
`define BASE_GPIO           8'h01
`define BASE_UART           8'h02

`define MEM_WORDS           256
`define RESET_HOLD_CYCLES   255
// Short bit time keeps simulation fast
`define UART_CLKS_PER_BIT   8
`define UART_FIFO_DEPTH     8
`endif

// ==== bus_pkg.sv ====
// ------------------------------------------------
// Bus package
// Word and strobe types of the native memory bus,
// the address region enum and a byte merge helper
// ------------------------------------------------
package bus_pkg;

    typedef logic [31:0] bus_word_t;
    typedef logic [3:0]  bus_strb_t;

    // Region picked by the top address byte
    typedef enum logic [1:0] {
        REGION_MEM,
        REGION_GPIO,
        REGION_UART,
        REGION_NONE
    } bus_region_e;

    // Replace only the bytes flagged in strb
    function automatic bus_word_t strb_merge(bus_word_t old_word, bus_word_t new_word,
                                             bus_strb_t strb);
        bus_word_t res;
        res = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return res;
    endfunction

endpackage

// ==== periph_pkg.sv ====
// ------------------------------------------------
// Peripheral package
// Register offsets of GPIO and UART, UART FSM states
// ------------------------------------------------
package periph_pkg;

    // GPIO word offsets
    typedef enum logic [1:0] {
        GPIO_OUT = 2'd0,
        GPIO_OE  = 2'd1,
        GPIO_IN  = 2'd2
    } gpio_reg_e;

    // UART word offsets
    // Status bit 0 empty, bit 1 full, bit 2 busy, bits 11:8 count
    typedef enum logic {
        UART_TXDATA = 1'b0,
        UART_STATUS = 1'b1
    } uart_reg_e;

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

endpackage

// ==== periph_bus_if.sv ====
// ------------------------------------------------
// Peripheral bus interface
// One region's request and return path between the
// decoder and a single peripheral
// ------------------------------------------------
`timescale 1ns/1ps

interface periph_bus_if;
    import bus_pkg::*;

    // Request with addr as a word offset inside the region
    logic      valid;
    bus_word_t addr;
    bus_word_t wdata;
    bus_strb_t wstrb;

    // Return path with rdata held at zero while ready is low
    logic      ready;
    bus_word_t rdata;

    modport host (
        output valid, addr, wdata, wstrb,
        input  ready, rdata
    );

    modport periph (
        input  valid, addr, wdata, wstrb,
        output ready, rdata
    );

endinterface

// ==== reset_hold.sv ====
// ------------------------------------------------
// Reset hold
// Keeps the fabric reset asserted for a fixed count
// of clocks after the external reset is released
// ------------------------------------------------
`timescale 1ns/1ps
`include "soc_settings.svh"

module reset_hold (
    input  logic clk,
    input  logic rst,
    output logic sys_rst
);

    localparam int CNT_W = $clog2(`RESET_HOLD_CYCLES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`RESET_HOLD_CYCLES - 1);

    logic [CNT_W-1:0] cnt;

    // Count up from release, saturate at the last value
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt     <= '0;
            sys_rst <= 1'b1;
        end else begin
            if (cnt != CNT_LAST) begin
                cnt <= cnt + 1'b1;
            end
            // Drops on the edge that completes the hold
            sys_rst <= (cnt != CNT_LAST);
        end
    end

endmodule

// ==== bus_decoder.sv ====
// ------------------------------------------------
// Bus decoder
// Routes a request by its top address byte to one
// peripheral and ORs the returns back together
// ------------------------------------------------
`timescale 1ns/1ps
`include "soc_settings.svh"

module bus_decoder (
    input  logic               clk,
    input  logic               sys_rst,
    input  logic               mem_valid,
    input  bus_pkg::bus_word_t mem_addr,
    input  bus_pkg::bus_word_t mem_wdata,
    input  bus_pkg::bus_strb_t mem_wstrb,
    output logic               mem_ready,
    output bus_pkg::bus_word_t mem_rdata,
    periph_bus_if.host         mem_bus,
    periph_bus_if.host         gpio_bus,
    periph_bus_if.host         uart_bus
);
    import bus_pkg::*;

    bus_region_e region;
    logic        req;
    logic        none_ready;

    // Region from the top byte
    always_comb begin
        case (mem_addr[31:24])
            `BASE_MEM:  region = REGION_MEM;
            `BASE_GPIO: region = REGION_GPIO;
            `BASE_UART: region = REGION_UART;
            default:    region = REGION_NONE;
        endcase
    end

    // Requests wait while the fabric is held in reset
    assign req = mem_valid && !sys_rst;

    assign mem_bus.valid  = req && (region == REGION_MEM);
    assign gpio_bus.valid = req && (region == REGION_GPIO);
    assign uart_bus.valid = req && (region == REGION_UART);

    // Byte address to word offset and payload broadcast
    assign mem_bus.addr   = {10'b0, mem_addr[23:2]};
    assign gpio_bus.addr  = {10'b0, mem_addr[23:2]};
    assign uart_bus.addr  = {10'b0, mem_addr[23:2]};
    assign mem_bus.wdata  = mem_wdata;
    assign gpio_bus.wdata = mem_wdata;
    assign uart_bus.wdata = mem_wdata;
    assign mem_bus.wstrb  = mem_wstrb;
    assign gpio_bus.wstrb = mem_wstrb;
    assign uart_bus.wstrb = mem_wstrb;

    // Unmapped region answered after one wait cycle
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            none_ready <= 1'b0;
        end else begin
            none_ready <= req && (region == REGION_NONE) && !none_ready;
        end
    end

    // Returns are zero when idle so a plain OR merges them
    assign mem_ready = mem_bus.ready | gpio_bus.ready | uart_bus.ready | none_ready;
    assign mem_rdata = mem_bus.rdata | gpio_bus.rdata | uart_bus.rdata;

endmodule

// ==== sram_port.sv ====
// ------------------------------------------------
// SRAM port
// Word array with byte strobe writes and a
// registered single cycle response
// ------------------------------------------------
`timescale 1ns/1ps
`include "soc_settings.svh"

module sram_port (
    input  logic       clk,
    periph_bus_if.periph bus
);
    import bus_pkg::*;

    localparam int IDX_W = $clog2(`MEM_WORDS);

    bus_word_t        mem [`MEM_WORDS];
    bus_word_t        rd_q;
    logic             ready_q;
    logic             req;
    logic [IDX_W-1:0] idx;

    // Ignore a held valid on the cycle after a ready
    assign req = bus.valid && !ready_q;
    // Upper offset bits alias onto the array
    assign idx = bus.addr[IDX_W-1:0];

    // One cycle ready pulse
    always_ff @(posedge clk) begin
        ready_q <= req;
    end

    // Storage and read data
    always_ff @(posedge clk) begin
        if (req) begin
            if (bus.wstrb != '0) begin
                mem[idx] <= strb_merge(mem[idx], bus.wdata, bus.wstrb);
            end
            // Read data is the old contents of the word
            rd_q <= mem[idx];
        end
    end

    assign bus.ready = ready_q;
    assign bus.rdata = ready_q ? rd_q : '0;

endmodule

// ==== gpio_port.sv ====
// ------------------------------------------------
// GPIO port
// Output and enable registers, synchronised inputs
// ------------------------------------------------
`timescale 1ns/1ps

module gpio_port (
    input  logic               clk,
    input  logic               sys_rst,
    periph_bus_if.periph       bus,
    input  bus_pkg::bus_word_t gpio_in,
    output bus_pkg::bus_word_t gpio_out,
    output bus_pkg::bus_word_t gpio_oe
);
    import bus_pkg::*;
    import periph_pkg::*;

    bus_word_t out_q;
    bus_word_t oe_q;
    bus_word_t in_meta;
    bus_word_t in_sync;
    bus_word_t rd_q;
    logic      ready_q;
    logic      req;
    gpio_reg_e sel;

    assign req = bus.valid && !ready_q;
    assign sel = gpio_reg_e'(bus.addr[1:0]);

    // Two flop input synchroniser
    always_ff @(posedge clk) begin
        in_meta <= gpio_in;
        in_sync <= in_meta;
    end

    // Control registers and ready pulse
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            out_q   <= '0;
            oe_q    <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= req;
            if (req && bus.wstrb != '0) begin
                // GPIO_IN and offset 3 ignore writes
                case (sel)
                    GPIO_OUT: out_q <= strb_merge(out_q, bus.wdata, bus.wstrb);
                    GPIO_OE:  oe_q  <= strb_merge(oe_q, bus.wdata, bus.wstrb);
                    default:  ;
                endcase
            end
        end
    end

    // Read mux
    always_ff @(posedge clk) begin
        if (req) begin
            case (sel)
                GPIO_OUT: rd_q <= out_q;
                GPIO_OE:  rd_q <= oe_q;
                GPIO_IN:  rd_q <= in_sync;
                default:  rd_q <= '0;
            endcase
        end
    end

    assign bus.ready = ready_q;
    assign bus.rdata = ready_q ? rd_q : '0;
    assign gpio_out  = out_q;
    assign gpio_oe   = oe_q;

endmodule

// ==== uart_tx_fsm.sv ====
// ------------------------------------------------
// UART transmit FSM
// Frames one byte as 8N1, LSB first, with a baud
// divider and a bit counter
// ------------------------------------------------
`timescale 1ns/1ps
`include "soc_settings.svh"

module uart_tx_fsm (
    input  logic       clk,
    input  logic       sys_rst,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    output logic       byte_pop,
    output logic       busy,
    output logic       tx
);
    import periph_pkg::*;

    localparam int DIV_W = $clog2(`UART_CLKS_PER_BIT);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`UART_CLKS_PER_BIT - 1);

    uart_state_e      state;
    logic [DIV_W-1:0] div;
    logic [2:0]       bit_cnt;
    logic [7:0]       shift;
    logic             tick;

    // Last clock of the current bit
    assign tick = (div == DIV_LAST);

    // Take a byte from the FIFO when leaving idle
    assign byte_pop = (state == UART_IDLE) && byte_valid;
    assign busy     = (state != UART_IDLE);

    // ------------------------------------------------
    // State, divider and bit counter
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            state   <= UART_IDLE;
            div     <= '0;
            bit_cnt <= '0;
        end else begin
            // Divider restarts on each state change
            div <= (tick || state == UART_IDLE) ? '0 : div + 1'b1;
            case (state)
                UART_IDLE: begin
                    if (byte_valid) begin
                        state <= UART_START;
                    end
                end
                UART_START: begin
                    if (tick) begin
                        state   <= UART_DATA;
                        bit_cnt <= '0;
                    end
                end
                UART_DATA: begin
                    if (tick) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= UART_STOP;
                        end
                    end
                end
                UART_STOP: begin
                    if (tick) begin
                        state <= UART_IDLE;
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

    // Shift register loaded on pop and shifted after each data bit
    always_ff @(posedge clk) begin
        if (byte_pop) begin
            shift <= byte_data;
        end else if (state == UART_DATA && tick) begin
            shift <= {1'b0, shift[7:1]};
        end
    end

    // Line level per state with idle high
    always_comb begin
        case (state)
            UART_START: tx = 1'b0;
            UART_DATA:  tx = shift[0];
            default:    tx = 1'b1;
        endcase
    end

endmodule

// ==== uart_port.sv ====
// ------------------------------------------------
// UART port
// Register decode and transmit FIFO, stalls writes
// while full, feeds the serialiser
// ------------------------------------------------
`timescale 1ns/1ps
`include "soc_settings.svh"

module uart_port (
    input  logic         clk,
    input  logic         sys_rst,
    periph_bus_if.periph bus,
    output logic         tx,
    output logic         irq_empty
);
    import bus_pkg::*;
    import periph_pkg::*;

    localparam int PTR_W = $clog2(`UART_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`UART_FIFO_DEPTH + 1);

    logic [7:0]       fifo [`UART_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             empty;
    logic             full;
    logic             busy;
    logic             pop;
    logic             push;
    logic             req;
    logic             tx_write;
    logic             ready_q;
    bus_word_t        rd_q;
    bus_word_t        status;
    uart_reg_e        sel;

    assign sel      = uart_reg_e'(bus.addr[0]);
    assign req      = bus.valid && !ready_q;
    assign tx_write = (sel == UART_TXDATA) && (bus.wstrb != '0);
    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(`UART_FIFO_DEPTH));
    // Held write completes once the FSM frees an entry
    assign push     = req && tx_write && !full;

    // Status word layout
    always_comb begin
        status             = '0;
        status[0]          = empty;
        status[1]          = full;
        status[2]          = busy;
        status[8 +: CNT_W] = count;
    end

    // ------------------------------------------------
    // FIFO pointers, count and ready
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            ready_q <= 1'b0;
        end else begin
            // Back-pressure only on a TXDATA write into a full FIFO
            ready_q <= req && !(tx_write && full);
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // FIFO storage and read data
    always_ff @(posedge clk) begin
        if (push) begin
            fifo[wr_ptr] <= bus.wdata[7:0];
        end
        if (req) begin
            rd_q <= (sel == UART_STATUS) ? status : '0;
        end
    end

    uart_tx_fsm u_tx (
        .clk        (clk),
        .sys_rst    (sys_rst),
        .byte_valid (!empty),
        .byte_data  (fifo[rd_ptr]),
        .byte_pop   (pop),
        .busy       (busy),
        .tx         (tx)
    );

    assign bus.ready = ready_q;
    assign bus.rdata = ready_q ? rd_q : '0;
    assign irq_empty = empty;

endmodule

// ==== soc_top.sv ====
// ------------------------------------------------
// SoC top
// Reset hold, bus decoder, SRAM, GPIO and UART
// behind a native valid/ready memory bus
// ------------------------------------------------
`timescale 1ns/1ps

module soc_top (
    input  logic               clk,
    input  logic               rst,
    // Memory bus from the external master
    input  logic               mem_valid,
    input  bus_pkg::bus_word_t mem_addr,
    input  bus_pkg::bus_word_t mem_wdata,
    input  bus_pkg::bus_strb_t mem_wstrb,
    output logic               mem_ready,
    output bus_pkg::bus_word_t mem_rdata,
    // GPIO pins with the pad split into in, out and enable
    input  bus_pkg::bus_word_t gpio_in,
    output bus_pkg::bus_word_t gpio_out,
    output bus_pkg::bus_word_t gpio_oe,
    // Serial line and FIFO empty interrupt
    output logic               uart_tx,
    output logic               uart_irq
);

    logic sys_rst;

    periph_bus_if mem_bus ();
    periph_bus_if gpio_bus ();
    periph_bus_if uart_bus ();

    // ------------------------------------------------
    // Reset and bus fabric
    // ------------------------------------------------
    reset_hold u_reset (
        .clk     (clk),
        .rst     (rst),
        .sys_rst (sys_rst)
    );

    bus_decoder u_decoder (
        .clk       (clk),
        .sys_rst   (sys_rst),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .mem_bus   (mem_bus.host),
        .gpio_bus  (gpio_bus.host),
        .uart_bus  (uart_bus.host)
    );

    // ------------------------------------------------
    // Peripherals
    // ------------------------------------------------
    sram_port u_sram (
        .clk (clk),
        .bus (mem_bus.periph)
    );

    gpio_port u_gpio (
        .clk      (clk),
        .sys_rst  (sys_rst),
        .bus      (gpio_bus.periph),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe)
    );

    uart_port u_uart (
        .clk       (clk),
        .sys_rst   (sys_rst),
        .bus       (uart_bus.periph),
        .tx        (uart_tx),
        .irq_empty (uart_irq)
    );

endmodule

// ==== tb_soc_top.sv ====
// ------------------------------------------------
// SoC testbench
// Random bus master with a reference model, a
// serial monitor on uart_tx and a cycle timeout
// ------------------------------------------------
`timescale 1ns/1ps
`include "soc_settings.svh"

module tb_soc_top;
    import bus_pkg::*;
    import periph_pkg::*;

    localparam int N_SRAM_WORDS  = 32;
    localparam int N_SRAM_WRITES = 40;
    localparam int N_UART_BYTES  = 20;
    localparam int FRAME_CYCLES  = 10 * `UART_CLKS_PER_BIT;
    // Requests over all tests at a few cycles each
    localparam int N_REQUESTS    = 2 * N_SRAM_WORDS + N_SRAM_WRITES + N_UART_BYTES + 40;
    localparam int TIMEOUT_CYCLES = `RESET_HOLD_CYCLES + 8 * N_REQUESTS
                                    + 2 * (N_UART_BYTES + 1) * FRAME_CYCLES + 2000;

    logic      clk;
    logic      rst;
    logic      mem_valid;
    bus_word_t mem_addr;
    bus_word_t mem_wdata;
    bus_strb_t mem_wstrb;
    logic      mem_ready;
    bus_word_t mem_rdata;
    bus_word_t gpio_in;
    bus_word_t gpio_out;
    bus_word_t gpio_oe;
    logic      uart_tx;
    logic      uart_irq;

    // Reference model state
    bus_word_t  shadow [`MEM_WORDS];
    bus_word_t  model_out;
    bus_word_t  model_oe;
    logic [7:0] exp_q [$];

    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     fails = 0;
    int     test_num = 0;
    int     errs_at_start = 0;
    int     rx_count = 0;
    int     cycle_cnt = 0;

    soc_top DUT (
        .clk       (clk),
        .rst       (rst),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .gpio_oe   (gpio_oe),
        .uart_tx   (uart_tx),
        .uart_irq  (uart_irq)
    );

    always #5 clk = ~clk;

    // Run limit from the test lengths
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------
    // Compare tasks and model helpers
    // ------------------------------------------------
    task automatic check_word(input string what, input bus_word_t got, input bus_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: uart byte %0d is %h, expected %h",
                     $time, rx_count, got, exp);
        end
    endtask

    // Byte lanes picked by the strobe come from the new word
    function automatic bus_word_t apply_strobe(bus_word_t old_w, bus_word_t new_w,
                                               bus_strb_t strb);
        bus_word_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    // Start value of an SRAM word from all index bits
    function automatic bus_word_t sram_fill(logic [7:0] a);
        return {a ^ 8'hC3, ~a, a + 8'h5A, a};
    endfunction

    function automatic bus_word_t sram_addr(logic [7:0] a);
        return {`BASE_MEM, 14'b0, a, 2'b00};
    endfunction

    function automatic bus_word_t gpio_addr(gpio_reg_e r);
        return {`BASE_GPIO, 20'b0, r, 2'b00};
    endfunction

    function automatic bus_word_t uart_addr(uart_reg_e r);
        return {`BASE_UART, 21'b0, r, 2'b00};
    endfunction

    // ------------------------------------------------
    // Bus master
    // ------------------------------------------------
    // Called on a falling edge and counts wait cycles beyond the minimum
    task automatic bus_access(input bus_word_t addr, input bus_word_t wdata,
                              input bus_strb_t strb, output bus_word_t rdata,
                              output int waits);
        waits     = 0;
        mem_valid = 1'b1;
        mem_addr  = addr;
        mem_wdata = wdata;
        mem_wstrb = strb;
        @(negedge clk);
        while (!mem_ready) begin
            waits++;
            @(negedge clk);
        end
        rdata = mem_rdata;
        // Held through the completing edge
        @(negedge clk);
        mem_valid = 1'b0;
        mem_wstrb = '0;
    endtask

    task automatic bus_write(input bus_word_t addr, input bus_word_t data, input bus_strb_t strb);
        bus_word_t unused;
        int        waits;
        bus_access(addr, data, strb, unused, waits);
    endtask

    task automatic bus_read(input bus_word_t addr, output bus_word_t data);
        int waits;
        bus_access(addr, '0, 4'h0, data, waits);
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (errors == errs_at_start) begin
            $display("Test %0d %s: passed", test_num, name);
        end else begin
            fails++;
            $display("Test %0d %s: %0d errors", test_num, name, errors - errs_at_start);
        end
        errs_at_start = errors;
    endtask

    // ------------------------------------------------
    // Serial monitor sampling bit centres on the falling clock
    // ------------------------------------------------
    initial begin : serial_monitor
        logic [7:0] rx_byte;
        forever begin
            @(negedge uart_tx);
            repeat (`UART_CLKS_PER_BIT / 2) @(negedge clk);
            if (uart_tx !== 1'b0) begin
                errors++;
                $display("Start bit on uart_tx did not stay low at %0t ns", $time);
            end
            // LSB first
            for (int i = 0; i < 8; i++) begin
                repeat (`UART_CLKS_PER_BIT) @(negedge clk);
                rx_byte[i] = uart_tx;
            end
            repeat (`UART_CLKS_PER_BIT) @(negedge clk);
            if (uart_tx !== 1'b1) begin
                errors++;
                $display("Stop bit on uart_tx was not high at %0t ns", $time);
            end
            if (exp_q.size() == 0) begin
                errors++;
                $display("Byte %h arrived on uart_tx with none expected", rx_byte);
            end else begin
                check_byte(rx_byte, exp_q.pop_front());
            end
            rx_count++;
        end
    end

    // ------------------------------------------------
    // Test sequence
    // ------------------------------------------------
    initial begin
        bus_word_t  rd;
        bus_word_t  val;
        bus_word_t  rnd;
        bus_strb_t  strb;
        logic [7:0] idx;
        logic [7:0] top;
        int         waits;
        int         stalls;
        seed      = 61914;
        clk       = 1'b0;
        rst       = 1'b1;
        mem_valid = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        mem_wstrb = '0;
        gpio_in   = '0;
        model_out = '0;
        model_oe  = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        // Reset values, then a request straight into the hold
        check_word("uart_tx after reset", {31'b0, uart_tx}, 32'h1);
        check_word("gpio_out after reset", gpio_out, '0);
        check_word("gpio_oe after reset", gpio_oe, '0);
        check_word("uart_irq after reset", {31'b0, uart_irq}, 32'h1);
        bus_access(gpio_addr(GPIO_OUT), '0, 4'h0, rd, waits);
        check_word("GPIO_OUT after reset", rd, '0);
        if (waits < `RESET_HOLD_CYCLES) begin
            errors++;
            $display("Request answered after %0d waits, inside the reset hold", waits);
        end
        end_test("reset and hold");

        // Full word fill, random strobe writes, read back
        for (int i = 0; i < N_SRAM_WORDS; i++) begin
            idx         = i[7:0];
            shadow[idx] = sram_fill(idx);
            bus_write(sram_addr(idx), shadow[idx], 4'hF);
        end
        for (int n = 0; n < N_SRAM_WRITES; n++) begin
            rnd  = $random(seed);
            val  = $random(seed);
            idx  = {3'b000, rnd[4:0]};
            strb = rnd[11:8];
            // Zero strobe would be a read
            if (strb == 4'h0) begin
                strb = 4'h6;
            end
            bus_write(sram_addr(idx), val, strb);
            shadow[idx] = apply_strobe(shadow[idx], val, strb);
        end
        for (int i = 0; i < N_SRAM_WORDS; i++) begin
            idx = i[7:0];
            bus_read(sram_addr(idx), rd);
            check_word($sformatf("SRAM word %0d", idx), rd, shadow[idx]);
        end
        end_test("SRAM strobes");

        // GPIO registers, pins and synchronised input
        for (int n = 0; n < 4; n++) begin
            val = $random(seed);
            bus_write(gpio_addr(GPIO_OUT), val, 4'hF);
            model_out = val;
            val  = $random(seed);
            rnd  = $random(seed);
            strb = rnd[3:0];
            bus_write(gpio_addr(GPIO_OE), val, strb);
            model_oe = apply_strobe(model_oe, val, strb);
            check_word("gpio_out pins", gpio_out, model_out);
            check_word("gpio_oe pins", gpio_oe, model_oe);
            bus_read(gpio_addr(GPIO_OUT), rd);
            check_word("GPIO_OUT read", rd, model_out);
            bus_read(gpio_addr(GPIO_OE), rd);
            check_word("GPIO_OE read", rd, model_oe);
            gpio_in = $random(seed);
            repeat (4) @(negedge clk);
            bus_read(gpio_addr(GPIO_IN), rd);
            check_word("GPIO_IN read", rd, gpio_in);
        end
        bus_write(gpio_addr(GPIO_IN), 32'hFFFF_FFFF, 4'hF);
        bus_read(gpio_addr(GPIO_OUT), rd);
        check_word("GPIO_OUT after GPIO_IN write", rd, model_out);
        bus_read(gpio_addr(GPIO_OE), rd);
        check_word("GPIO_OE after GPIO_IN write", rd, model_oe);
        end_test("GPIO");

        // Idle status, then a burst deep enough to stall
        bus_read(uart_addr(UART_STATUS), rd);
        check_word("UART_STATUS idle", rd, 32'h0000_0001);
        stalls = 0;
        for (int n = 0; n < N_UART_BYTES; n++) begin
            val = $random(seed);
            exp_q.push_back(val[7:0]);
            bus_access(uart_addr(UART_TXDATA), val, 4'h1, rd, waits);
            if (waits > 0) begin
                stalls++;
            end
        end
        if (stalls == 0) begin
            errors++;
            $display("No UART_TXDATA write stalled, the FIFO never filled");
        end
        check_word("uart_irq during burst", {31'b0, uart_irq}, 32'h0);
        end_test("UART burst");

        // Full and busy with 8 queued, then drain
        bus_read(uart_addr(UART_STATUS), rd);
        check_word("UART_STATUS after burst", rd, 32'h0000_0806);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2 * `UART_CLKS_PER_BIT) @(negedge clk);
        check_word("uart_irq after drain", {31'b0, uart_irq}, 32'h1);
        bus_read(uart_addr(UART_STATUS), rd);
        check_word("UART_STATUS after drain", rd, 32'h0000_0001);
        if (rx_count != N_UART_BYTES) begin
            errors++;
            $display("Received %0d UART bytes instead of %0d", rx_count, N_UART_BYTES);
        end
        end_test("UART status and drain");

        // Unmapped top bytes 03 to FF
        for (int n = 0; n < 4; n++) begin
            rnd = $random(seed);
            val = $random(seed);
            top = 8'h03 + (rnd[7:0] % 8'd253);
            idx = {3'b000, rnd[12:8]};
            bus_read({top, 14'b0, idx, 2'b00}, rd);
            check_word("unmapped read", rd, '0);
            bus_write({top, 14'b0, idx, 2'b00}, val, 4'hF);
            bus_read(sram_addr(idx), rd);
            check_word("SRAM after unmapped write", rd, shadow[idx]);
        end
        end_test("unmapped region");

        $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 test_num, fails, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
bus_pkg.sv
periph_pkg.sv
periph_bus_if.sv
reset_hold.sv
bus_decoder.sv
sram_port.sv
gpio_port.sv
uart_tx_fsm.sv
uart_port.sv
soc_top.sv
tb_soc_top.sv

// ==== Makefile ====
# Verilator build and run of the SoC testbench
VERILATOR ?= verilator
TOP       ?= tb_soc_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
